/* instr_seq.f */
+incdir+include
verilog/instr_seq_pkg.sv
verilog/instruction_buffer.sv
verilog/instr_decode_stage.sv
verilog/instr_exec_stage.sv
verilog/instr_seq_top.sv
tb/instr_seq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f instr_seq.f --top-module instr_seq_tb -o instr_seq_sim

./obj_dir/instr_seq_sim 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "Run finished: PASS"
else
    echo "Run finished: FAIL"
    exit 1
fi

/* tb/instr_seq_tb.sv */
`timescale 1ns/1ps
`include "instr_seq_macros.svh"

module instr_seq_tb;

    import instr_seq_pkg::*;

    localparam int WAIT_LIMIT       = 1000;
    localparam int POST_DONE_CYCLES = 60;

    logic        rd_clk;
    logic        wr_clk;
    logic        rst;
    logic        wr_valid;
    instr_t      wr_data;
    logic        out_req;
    logic        out_ack;
    acc_t        out_data;
    logic        done;
    logic        illegal_op;

    instr_t      prog [`MAX_INSTRUCTIONS];
    int          prog_len;
    int          write_gap [`MAX_INSTRUCTIONS];
    int          ack_delay [`MAX_INSTRUCTIONS];
    int          release_delay [`MAX_INSTRUCTIONS];
    acc_t        expected_q [$];
    logic        expect_illegal;
    logic [31:0] lfsr_state = 32'ha8cb;

    instr_seq_top instr_seq_top_inst (
        .rd_clk     (rd_clk),
        .wr_clk     (wr_clk),
        .rst        (rst),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_data   (out_data),
        .done       (done),
        .illegal_op (illegal_op)
    );

    initial begin
        rd_clk = 1'b0;
        forever #2 rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #3 wr_clk = ~wr_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic operand_t random_operand();
        return operand_t'(take_bits(24));
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                                     name, actual, expected));
        end
    endtask

    task automatic append_word(input logic last, input logic [5:0] opcode,
                               input operand_t operand);
        prog[prog_len] = {last, 1'b1, opcode, operand};
        prog_len++;
    endtask

    task automatic build_program();
        int      sel;
        opcode_t op;
        prog_len = 0;
        append_word(1'b0, OP_LOAD, 24'h123456);
        append_word(1'b0, OP_ADD, random_operand());
        append_word(1'b0, OP_EMIT, '0);
        append_word(1'b0, OP_XOR, random_operand());
        append_word(1'b0, OP_EMIT, '0);
        append_word(1'b0, OP_SHL, random_operand());
        append_word(1'b0, OP_EMIT, '0);
        // 0xffffff00 plus 0x1ff wraps to 0xff; 0x28 shifts by 8
        append_word(1'b0, OP_LOAD, 24'hffffff);
        append_word(1'b0, OP_SHL, 24'h000028);
        append_word(1'b0, OP_ADD, 24'h0001ff);
        append_word(1'b0, OP_EMIT, '0);
        // Opcode 0x2a is outside the instruction set
        append_word(1'b0, 6'h2a, random_operand());
        append_word(1'b0, OP_EMIT, '0);
        append_word(1'b0, OP_NOP, random_operand());
        for (int k = 0; k < 6; k++) begin
            sel = int'(take_bits(2));
            case (sel)
                1:       op = OP_XOR;
                2:       op = OP_SHL;
                default: op = OP_ADD;
            endcase
            append_word(1'b0, op, random_operand());
            append_word(1'b0, OP_EMIT, '0);
        end
        append_word(1'b0, OP_LOAD, random_operand());
        append_word(1'b1, OP_EMIT, '0);
        // Sits behind the last word and must never run
        append_word(1'b0, OP_EMIT, '0);
    endtask

    // Runs the program up to the last-flagged word
    function automatic logic run_reference();
        acc_t       acc;
        logic       illegal;
        logic       last;
        logic [5:0] opcode;
        operand_t   operand;
        acc     = '0;
        illegal = 1'b0;
        last    = 1'b0;
        for (int i = 0; i < prog_len && !last; i++) begin
            opcode  = prog[i][`VALID_BIT-1:`OPCODE_LSB];
            operand = prog[i][`OPCODE_LSB-1:0];
            last    = prog[i][`LAST_BIT];
            case (opcode)
                OP_NOP:  acc = acc;
                OP_LOAD: acc = {8'h00, operand};
                OP_ADD:  acc = acc + {8'h00, operand};
                OP_XOR:  acc = acc ^ {8'h00, operand};
                // Only the low five bits count
                OP_SHL:  acc = acc << operand[4:0];
                OP_EMIT: expected_q.push_back(acc);
                default: illegal = 1'b1;
            endcase
        end
        return illegal;
    endfunction

    task automatic write_program();
        for (int i = 0; i < prog_len; i++) begin
            repeat (write_gap[i]) begin
                @(negedge wr_clk);
                wr_valid <= 1'b0;
            end
            @(negedge wr_clk);
            wr_valid <= 1'b1;
            wr_data  <= prog[i];
        end
        @(negedge wr_clk);
        wr_valid <= 1'b0;
    endtask

    task automatic consume_results();
        int   cycles;
        int   n;
        logic finished;
        acc_t expected;
        n        = 0;
        finished = 1'b0;
        while (!finished) begin
            cycles = 0;
            @(negedge rd_clk);
            while (!out_req && !done) begin
                if (cycles == WAIT_LIMIT) begin
                    report_failure("Timed out waiting for a result or for done");
                end
                cycles++;
                @(negedge rd_clk);
            end
            if (out_req) begin
                if (expected_q.size() == 0) begin
                    report_failure("out_req rose with no result left to expect");
                end
                expected = expected_q.pop_front();
                check_value("out_data", out_data, expected);
                check_value("done", 32'(done), 32'd0);
                // Request and data hold until the ack arrives
                repeat (ack_delay[n]) begin
                    @(negedge rd_clk);
                    check_value("out_req", 32'(out_req), 32'd1);
                    check_value("out_data", out_data, expected);
                end
                out_ack <= 1'b1;
                cycles = 0;
                @(negedge rd_clk);
                while (out_req) begin
                    if (cycles == WAIT_LIMIT) begin
                        report_failure("Timed out waiting for out_req to fall");
                    end
                    cycles++;
                    @(negedge rd_clk);
                end
                // Nothing new starts while the ack is still high
                repeat (release_delay[n]) begin
                    @(negedge rd_clk);
                    check_value("out_req", 32'(out_req), 32'd0);
                    check_value("done", 32'(done), 32'd0);
                end
                out_ack <= 1'b0;
                n++;
            end else begin
                finished = 1'b1;
            end
        end
    endtask

    initial begin
        rst      = 1'b1;
        wr_valid = 1'b0;
        wr_data  = '0;
        out_ack  = 1'b0;
        build_program();
        expect_illegal = run_reference();
        for (int i = 0; i < `MAX_INSTRUCTIONS; i++) begin
            // Burst at the start, then slower than execution
            write_gap[i]     = (i < 10) ? 0 : 4 + int'(take_bits(3));
            ack_delay[i]     = int'(take_bits(3));
            release_delay[i] = int'(take_bits(2));
        end
        repeat (3) @(posedge rd_clk);
        @(negedge rd_clk);
        rst <= 1'b0;
        check_value("out_req", 32'(out_req), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("illegal_op", 32'(illegal_op), 32'd0);
        fork
            write_program();
            consume_results();
        join
        // Extra EMIT is in the buffer by now
        repeat (POST_DONE_CYCLES) begin
            @(negedge rd_clk);
            check_value("out_req", 32'(out_req), 32'd0);
            check_value("done", 32'(done), 32'd1);
        end
        check_value("illegal_op", 32'(illegal_op), 32'(expect_illegal));
        if (expected_q.size() != 0) begin
            report_failure($sformatf("%0d expected results never appeared",
                                     expected_q.size()));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* verilog/instr_seq_top.sv */
`timescale 1ns/1ps

module instr_seq_top (
    input  logic                  rd_clk,
    input  logic                  wr_clk,
    input  logic                  rst,
    input  logic                  wr_valid,
    input  instr_seq_pkg::instr_t wr_data,
    output logic                  out_req,
    input  logic                  out_ack,
    output instr_seq_pkg::acc_t   out_data,
    output logic                  done,
    output logic                  illegal_op
);

    import instr_seq_pkg::*;

    // Buffer to decode
    logic     buf_valid;
    logic     buf_ready;
    logic     buf_last;
    instr_t   buf_data;

    // Decode to execute
    logic     dec_req;
    logic     dec_ack;
    opcode_t  dec_opcode;
    operand_t dec_operand;
    logic     dec_illegal;
    logic     dec_last;

    instruction_buffer instruction_buffer_inst (
        .wr_clk    (wr_clk),
        .rd_clk    (rd_clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_data   (wr_data),
        .buf_ready (buf_ready),
        .buf_valid (buf_valid),
        .buf_last  (buf_last),
        .buf_data  (buf_data)
    );

    instr_decode_stage instr_decode_stage_inst (
        .rd_clk      (rd_clk),
        .rst         (rst),
        .buf_valid   (buf_valid),
        .buf_last    (buf_last),
        .buf_data    (buf_data),
        .buf_ready   (buf_ready),
        .dec_req     (dec_req),
        .dec_ack     (dec_ack),
        .dec_opcode  (dec_opcode),
        .dec_operand (dec_operand),
        .dec_illegal (dec_illegal),
        .dec_last    (dec_last)
    );

    instr_exec_stage instr_exec_stage_inst (
        .rd_clk      (rd_clk),
        .rst         (rst),
        .dec_req     (dec_req),
        .dec_ack     (dec_ack),
        .dec_opcode  (dec_opcode),
        .dec_operand (dec_operand),
        .dec_illegal (dec_illegal),
        .dec_last    (dec_last),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data),
        .done        (done),
        .illegal_op  (illegal_op)
    );

endmodule

/* verilog/instr_exec_stage.sv */
`timescale 1ns/1ps

module instr_exec_stage (
    input  logic                    rd_clk,
    input  logic                    rst,
    input  logic                    dec_req,
    output logic                    dec_ack,
    input  instr_seq_pkg::opcode_t  dec_opcode,
    input  instr_seq_pkg::operand_t dec_operand,
    input  logic                    dec_illegal,
    input  logic                    dec_last,
    output logic                    out_req,
    input  logic                    out_ack,
    output instr_seq_pkg::acc_t     out_data,
    output logic                    done,
    output logic                    illegal_op
);

    import instr_seq_pkg::*;

    exec_state_t state;
    acc_t        acc;
    acc_t        operand_ext;
    logic        accept;
    logic        cur_emit;
    logic        cur_last;

    assign operand_ext = acc_t'(dec_operand);
    assign accept      = (state == EX_IDLE) && dec_req;

    assign dec_ack = (state == EX_ACK);
    assign out_req = (state == EX_EMIT);
    assign done    = (state == EX_HALT);

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            state      <= EX_IDLE;
            acc        <= '0;
            illegal_op <= 1'b0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (accept) begin
                        state <= EX_ACK;
                        if (dec_illegal) begin
                            illegal_op <= 1'b1;
                        end
                        // Illegal words arrive as NOP and fall through
                        case (dec_opcode)
                            OP_LOAD: acc <= operand_ext;
                            OP_ADD:  acc <= acc + operand_ext;
                            OP_XOR:  acc <= acc ^ operand_ext;
                            OP_SHL:  acc <= acc << dec_operand;
                            default: acc <= acc;
                        endcase
                    end
                end
                EX_ACK: begin
                    // Decode saw the ack and released its request
                    if (!dec_req) begin
                        if (cur_emit) begin
                            state <= EX_EMIT;
                        end else if (cur_last) begin
                            state <= EX_HALT;
                        end else begin
                            state <= EX_IDLE;
                        end
                    end
                end
                EX_EMIT: begin
                    if (out_ack) begin
                        state <= EX_EMIT_WAIT;
                    end
                end
                EX_EMIT_WAIT: begin
                    if (!out_ack) begin
                        state <= cur_last ? EX_HALT : EX_IDLE;
                    end
                end
                EX_HALT: state <= EX_HALT;
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Flags of the accepted instruction and the result it emits
    always_ff @(posedge rd_clk) begin
        if (accept) begin
            cur_emit <= (dec_opcode == OP_EMIT);
            cur_last <= dec_last;
            if (dec_opcode == OP_EMIT) begin
                out_data <= acc;
            end
        end
    end

endmodule

/* verilog/instr_decode_stage.sv */
`timescale 1ns/1ps
`include "instr_seq_macros.svh"

module instr_decode_stage (
    input  logic                    rd_clk,
    input  logic                    rst,
    input  logic                    buf_valid,
    input  logic                    buf_last,
    input  instr_seq_pkg::instr_t   buf_data,
    output logic                    buf_ready,
    output logic                    dec_req,
    input  logic                    dec_ack,
    output instr_seq_pkg::opcode_t  dec_opcode,
    output instr_seq_pkg::operand_t dec_operand,
    output logic                    dec_illegal,
    output logic                    dec_last
);

    import instr_seq_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`INSTR_WIDTH);

    typedef enum logic {
        DEC_IDLE,
        DEC_REQ
    } dec_state_t;

    dec_state_t state;
    logic [`VALID_BIT-`OPCODE_LSB-1:0] raw_opcode;
    opcode_t    next_opcode;
    operand_t   next_operand;
    logic       next_illegal;
    logic       take;

    assign raw_opcode = buf_data[`VALID_BIT-1:`OPCODE_LSB];

    always_comb begin
        next_opcode  = OP_NOP;
        next_operand = buf_data[`OPCODE_LSB-1:0];
        next_illegal = 1'b0;
        case (raw_opcode)
            OP_NOP, OP_LOAD, OP_ADD, OP_XOR, OP_EMIT: begin
                next_opcode = opcode_t'(raw_opcode);
            end
            OP_SHL: begin
                next_opcode  = OP_SHL;
                // Shift amount fits the accumulator width
                next_operand = operand_t'(buf_data[SHAMT_WIDTH-1:0]);
            end
            default: begin
                next_illegal = 1'b1;
            end
        endcase
    end

    // Held off until execute has dropped its ack
    assign buf_ready = (state == DEC_IDLE) && !dec_ack;
    assign take      = buf_valid && buf_ready;
    assign dec_req   = (state == DEC_REQ);

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            state <= DEC_IDLE;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (take) begin
                        state <= DEC_REQ;
                    end
                end
                DEC_REQ: begin
                    if (dec_ack) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge rd_clk) begin
        if (take) begin
            dec_opcode  <= next_opcode;
            dec_operand <= next_operand;
            dec_illegal <= next_illegal;
            dec_last    <= buf_last;
        end
    end

endmodule

/* verilog/instruction_buffer.sv */
`timescale 1ns/1ps
`include "instr_seq_macros.svh"

module instruction_buffer (
    input  logic                  wr_clk,
    input  logic                  rd_clk,
    input  logic                  rst,
    input  logic                  wr_valid,
    input  instr_seq_pkg::instr_t wr_data,
    input  logic                  buf_ready,
    output logic                  buf_valid,
    output logic                  buf_last,
    output instr_seq_pkg::instr_t buf_data
);

    import instr_seq_pkg::*;

    localparam int ADDR_WIDTH = $clog2(`MAX_INSTRUCTIONS);

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Unwritten entries read as zero, so their valid bit is clear
    instr_t mem [`MAX_INSTRUCTIONS] = '{default: '0};

    addr_t  wr_ptr = '0;
    addr_t  rd_ptr;
    addr_t  rd_ptr_q;
    instr_t rd_word;
    instr_t rd_word_q;
    logic   word_stable;
    logic   transfer;

    always_ff @(posedge wr_clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
            wr_ptr      <= wr_ptr + 1'b1;
        end
    end

    // Registered read port plus one older sample
    always_ff @(posedge rd_clk) begin
        rd_word   <= mem[rd_ptr];
        rd_word_q <= rd_word;
    end

    assign transfer = buf_valid && buf_ready;

    // A word is offered only once two samples agree at a settled pointer
    always_ff @(posedge rd_clk) begin
        if (rst) begin
            rd_ptr      <= '0;
            rd_ptr_q    <= '0;
            word_stable <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            rd_ptr_q <= rd_ptr;
            if (transfer) begin
                rd_ptr      <= rd_ptr + 1'b1;
                word_stable <= 1'b0;
                buf_valid   <= 1'b0;
            end else begin
                word_stable <= rd_word_q[`VALID_BIT]
                               && (rd_word_q == rd_word)
                               && (rd_ptr_q == rd_ptr);
                buf_valid   <= word_stable;
            end
        end
    end

    assign buf_data = rd_word_q;
    assign buf_last = rd_word_q[`LAST_BIT];

endmodule

/* verilog/instr_seq_pkg.sv */
`include "instr_seq_macros.svh"

package instr_seq_pkg;

    // One word as written by the host
    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // Immediate field below the opcode
    typedef logic [`OPCODE_LSB-1:0] operand_t;

    typedef logic [`INSTR_WIDTH-1:0] acc_t;

    typedef enum logic [`VALID_BIT-`OPCODE_LSB-1:0] {
        OP_NOP  = 6'd0,
        OP_LOAD = 6'd1,
        OP_ADD  = 6'd2,
        OP_XOR  = 6'd3,
        OP_SHL  = 6'd4,
        OP_EMIT = 6'd5
    } opcode_t;

    // Execute stage FSM
    typedef enum logic [2:0] {
        EX_IDLE,
        EX_ACK,
        EX_EMIT,
        EX_EMIT_WAIT,
        EX_HALT
    } exec_state_t;

endpackage

/* include/instr_seq_macros.svh */
`ifndef INSTR_SEQ_MACROS_SVH
`define INSTR_SEQ_MACROS_SVH

// Instruction word layout
`define INSTR_WIDTH 32
`define LAST_BIT 31
`define VALID_BIT 30

// Opcode sits between the valid flag and this bit
`define OPCODE_LSB 24

// Buffer depth in words
`define MAX_INSTRUCTIONS 64

`endif
